// File: project.f
+incdir+include
verilog/n64_pkg.sv
verilog/n64_bit_timer.sv
verilog/n64_line_decoder.sv
verilog/n64_reply_tx.sv
verilog/n64_cmd_fsm.sv
verilog/n64_controller.sv
verif/n64_controller_props.sv
verif/n64_controller_tb.sv

// File: verif/n64_controller_tb.sv
`include "n64_params.svh"

module n64_controller_tb import n64_pkg::*; ();

    localparam int  US         = `N64_TICKS_PER_US;   // Clock cycles per microsecond
    localparam time GAP_MIN    = `N64_REPLY_GAP_US * US * 40;
    localparam time GAP_MAX    = ((`N64_REPLY_GAP_US + 1) * US + 4) * 40;
    localparam int  CMD_MAX_US = 9 * `N64_CELL_US + `N64_REPLY_GAP_US + 1
                               + 35 * `N64_CELL_US + `N64_IDLE_US + 4;
    localparam time WATCHDOG   = (40 * CMD_MAX_US + 200) * US * 40;

    logic         sample_clk = 1'b0;
    logic         arst_n;
    logic         host_low;
    n64_buttons_t buttons;
    logic         line_drive_low;
    wire          line_in = ~(host_low | line_drive_low);   // Wired-AND of both drivers
    int           mismatches;
    int           failures;

    n64_controller n64_controller_i (
        .sample_clk     (sample_clk),
        .arst_n         (arst_n),
        .line_in        (line_in),
        .buttons        (buttons),
        .line_drive_low (line_drive_low)
    );

    always #20 sample_clk = ~sample_clk;

    //////////////////////////////
    // Host side of the line
    //////////////////////////////

    task automatic wait_us(input int n);
        repeat (n * US) @(negedge sample_clk);
    endtask

    task automatic send_cell(input logic one);
        host_low = 1'b1;
        wait_us(one ? `N64_SHORT_LOW_US : `N64_LONG_LOW_US);
        host_low = 1'b0;
        wait_us(`N64_CELL_US - (one ? `N64_SHORT_LOW_US : `N64_LONG_LOW_US));
    endtask

    task automatic send_bits(input n64_cmd_t cmd, input int nbits);
        for (int i = 7; i > 7 - nbits; i--) begin
            send_cell(cmd[i]);                      // MSB first
        end
    endtask

    task automatic send_stop();
        host_low = 1'b1;
        wait_us(`N64_SHORT_LOW_US);
        host_low = 1'b0;                            // Rising edge the gap is measured from
    endtask

    task automatic check_quiet(input int n_us, input n64_cmd_t cmd);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < n_us * US && !seen; i++) begin
            @(negedge sample_clk);
            seen = line_drive_low;
        end
        assert (!seen) else begin
            failures++;
            $display("Controller pulled the line low at %0t after command 0x%02h",
                     $time, cmd);
        end
    endtask

    //////////////////////////////
    // Reply receiver and model
    //////////////////////////////

    // Last low phase before a silent cell is the stop cell
    task automatic receive_reply(output int nbits, output logic [31:0] data,
                                 output time start, output logic stop_ok);
        int   low_cnt;
        int   high_cnt;
        int   wait_cnt;
        logic pending;
        logic have_bit;
        nbits    = 0;
        data     = '0;
        start    = 0;
        stop_ok  = 1'b0;
        wait_cnt = 0;
        have_bit = 1'b0;
        do begin
            @(negedge sample_clk);
            wait_cnt++;
        end while (line_in && wait_cnt < (`N64_REPLY_GAP_US + 4) * US);
        if (!line_in) begin
            start    = $time;
            high_cnt = 0;
            while (high_cnt <= `N64_CELL_US * US) begin
                low_cnt = 0;
                while (!line_in) begin
                    @(negedge sample_clk);
                    low_cnt++;
                end
                high_cnt = 0;
                while (line_in && high_cnt <= `N64_CELL_US * US) begin
                    @(negedge sample_clk);
                    high_cnt++;
                end
                if (have_bit) begin
                    data  = {data[30:0], pending};
                    nbits++;
                end
                pending  = (low_cnt <= `N64_ONE_MAX_US * US);
                have_bit = 1'b1;
            end
            stop_ok = (low_cnt == `N64_SHORT_LOW_US * US);
        end
    endtask

    function automatic void expected_reply(input n64_cmd_t cmd, input n64_buttons_t btn,
                                           output int nbits, output logic [31:0] data);
        nbits = 0;
        data  = '0;
        if (cmd == 8'h00 || cmd == 8'hff) begin
            nbits = 24;
            data  = {8'h00, `N64_ID_BYTE0, `N64_ID_BYTE1, `N64_ID_BYTE2};
        end else if (cmd == 8'h01) begin
            nbits = 32;
            data  = btn;
        end
    endfunction

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        n64_cmd_t     cmd;
        n64_buttons_t held;
        int           sel;
        int           exp_bits;
        int           got_bits;
        logic [31:0]  exp_data;
        logic [31:0]  got_data;
        time          t_rise;
        time          t_start;
        logic         stop_ok;
        logic         force_known;
        void'($urandom(32'h6fc7_7d05));
        arst_n      = 1'b0;
        host_low    = 1'b0;
        buttons     = '0;
        mismatches  = 0;
        failures    = 0;
        force_known = 1'b0;
        repeat (2) @(negedge sample_clk);
        arst_n = 1'b1;
        check_quiet(20, 8'h00);                     // Idle host, idle controller
        for (int n = 0; n < 40; n++) begin
            sel = force_known ? $urandom % 7 : $urandom % 12;
            cmd = $urandom;
            case (sel)
                0, 1:       cmd = 8'h00;
                2:          cmd = 8'hff;
                3, 4, 5, 6: cmd = 8'h01;
                7:          cmd = ($urandom % 2) ? 8'h03 : 8'h02;
                8, 9: begin
                    while (cmd == 8'h00 || cmd == 8'h01 || cmd == 8'hff) begin
                        cmd = $urandom;
                    end
                end
                default: ;
            endcase
            if (sel >= 10) begin                    // Command cut off, then idle
                send_bits(cmd, 1 + $urandom % 7);
                check_quiet(`N64_IDLE_US + 4, cmd);
                force_known = 1'b1;
            end else begin
                buttons = $urandom;
                send_bits(cmd, 8);
                send_stop();
                t_rise = $time;
                held   = buttons;
                fork
                    begin
                        repeat (8) @(negedge sample_clk);
                        buttons = $urandom;         // Reply must keep the snapshot
                    end
                join_none
                expected_reply(cmd, held, exp_bits, exp_data);
                if (exp_bits == 0) begin
                    check_quiet(`N64_IDLE_US + 4, cmd);
                    force_known = 1'b1;
                end else begin
                    receive_reply(got_bits, got_data, t_start, stop_ok);
                    force_known = 1'b0;
                    assert (t_start != 0) else begin
                        failures++;
                        $display("No reply to command 0x%02h by %0t", cmd, $time);
                    end
                    if (t_start != 0) begin
                        assert (t_start - t_rise >= GAP_MIN && t_start - t_rise <= GAP_MAX)
                        else begin
                            mismatches++;
                            $display("Mismatch at %0t: reply to 0x%02h started %0t after stop",
                                     $time, cmd, t_start - t_rise);
                        end
                        assert (got_bits == exp_bits && got_data == exp_data) else begin
                            mismatches++;
                            $display("Mismatch at %0t: 0x%02h got %0d bits %h, exp %0d bits %h",
                                     $time, cmd, got_bits, got_data, exp_bits, exp_data);
                        end
                        assert (stop_ok) else begin
                            failures++;
                            $display("Reply stop cell to 0x%02h had the wrong length", cmd);
                        end
                    end
                    wait_us(`N64_CELL_US);
                end
            end
        end
        $display("Summary: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("Timeout: the run did not finish within %0t", WATCHDOG);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: verif/n64_controller_props.sv
module n64_controller_props import n64_pkg::*; (
    input logic        sample_clk,
    input logic        arst_n,
    input logic        line_drive_low,
    input logic        tx_busy,
    input logic        tx_start,
    input logic        expired,
    input n64_rx_bit_t rx_bit
);

    //////////////////////////////
    // Drive and strobe rules
    //////////////////////////////

    drive_needs_busy: assert property (@(posedge sample_clk) disable iff (!arst_n)
        line_drive_low |-> tx_busy)
        else $error("Line pulled low while the transmitter is idle");

    start_when_idle: assert property (@(posedge sample_clk) disable iff (!arst_n)
        tx_start |-> !tx_busy)
        else $error("tx_start raised while the transmitter is busy");

    rx_bit_pulse: assert property (@(posedge sample_clk) disable iff (!arst_n)
        rx_bit.valid |=> !rx_bit.valid)
        else $error("rx_bit.valid held for more than one cycle");

    expired_pulse: assert property (@(posedge sample_clk) disable iff (!arst_n)
        expired |=> !expired)
        else $error("expired held for more than one cycle");

    // Everything quiet while in reset
    reset_quiet: assert property (@(posedge sample_clk)
        !arst_n |-> !(line_drive_low || tx_busy || tx_start || rx_bit.valid || expired))
        else $error("Output or strobe active during reset");

endmodule

bind n64_controller n64_controller_props n64_controller_props_i (
    .sample_clk     (sample_clk),
    .arst_n         (arst_n),
    .line_drive_low (line_drive_low),
    .tx_busy        (tx_busy),
    .tx_start       (tx_start),
    .expired        (expired),
    .rx_bit         (rx_bit)
);

// File: verilog/n64_controller.sv
module n64_controller import n64_pkg::*; (
    input  logic         sample_clk,
    input  logic         arst_n,
    input  logic         line_in,
    input  n64_buttons_t buttons,
    output logic         line_drive_low
);

    logic        us_tick;
    logic        load;
    n64_us_t     load_us;
    logic        expired;
    n64_rx_bit_t rx_bit;
    logic        tx_start;
    n64_reply_t  tx_reply;
    logic        tx_busy;

    n64_bit_timer n64_bit_timer_i (
        .sample_clk (sample_clk),
        .arst_n     (arst_n),
        .load       (load),
        .load_us    (load_us),
        .us_tick    (us_tick),
        .expired    (expired)
    );

    // Also sees the controller's own reply cells
    n64_line_decoder n64_line_decoder_i (
        .sample_clk (sample_clk),
        .arst_n     (arst_n),
        .line_in    (line_in),
        .us_tick    (us_tick),
        .rx_bit     (rx_bit)
    );

    n64_cmd_fsm n64_cmd_fsm_i (
        .sample_clk (sample_clk),
        .arst_n     (arst_n),
        .rx_bit     (rx_bit),
        .expired    (expired),
        .tx_busy    (tx_busy),
        .buttons    (buttons),
        .load       (load),
        .load_us    (load_us),
        .tx_start   (tx_start),
        .tx_reply   (tx_reply)
    );

    n64_reply_tx n64_reply_tx_i (
        .sample_clk     (sample_clk),
        .arst_n         (arst_n),
        .us_tick        (us_tick),
        .tx_start       (tx_start),
        .tx_reply       (tx_reply),
        .tx_busy        (tx_busy),
        .line_drive_low (line_drive_low)    // Open drain, pull low only
    );

endmodule

// File: verilog/n64_cmd_fsm.sv
`include "n64_params.svh"

module n64_cmd_fsm import n64_pkg::*; (
    input  logic         sample_clk,
    input  logic         arst_n,
    input  n64_rx_bit_t  rx_bit,
    input  logic         expired,
    input  logic         tx_busy,
    input  n64_buttons_t buttons,
    output logic         load,
    output n64_us_t      load_us,
    output logic         tx_start,
    output n64_reply_t   tx_reply
);

    n64_state_t   state_q;
    n64_state_t   state_d;
    n64_cmd_t     cmd_q;
    n64_buttons_t buttons_q;
    logic [2:0]   bit_cnt;                  // Wraps to zero after the eighth bit
    logic         known_cmd;

    assign known_cmd = (cmd_q == CMD_INFO) || (cmd_q == CMD_STATUS) || (cmd_q == CMD_RESET);

    //////////////////////////////
    // Next state and timer control
    //////////////////////////////

    always_comb begin
        state_d  = state_q;
        load     = 1'b0;
        load_us  = n64_us_t'(`N64_IDLE_US);
        tx_start = 1'b0;
        case (state_q)
            AWAIT_CMD: begin
                if (rx_bit.valid) begin
                    load = 1'b1;                        // Idle timer per bit
                    if (bit_cnt == 3'd7) begin
                        state_d = AWAIT_STOP;
                    end
                end
            end
            AWAIT_STOP: begin
                if (rx_bit.valid) begin
                    load = 1'b1;
                    if (known_cmd) begin
                        load_us = n64_us_t'(`N64_REPLY_GAP_US);
                        state_d = REPLY_GAP;
                    end else begin
                        state_d = IGNORING;             // Read, write and unknown
                    end
                end else if (expired) begin
                    state_d = AWAIT_CMD;                // Stop cell never came
                end
            end
            REPLY_GAP: begin
                if (expired) begin
                    tx_start = 1'b1;
                    state_d  = RESPONDING;
                end
            end
            RESPONDING: begin
                if (!tx_busy) begin                     // Own cells dropped until done
                    state_d = AWAIT_CMD;
                end
            end
            IGNORING: begin
                if (rx_bit.valid) begin
                    load = 1'b1;
                end else if (expired) begin
                    state_d = AWAIT_CMD;
                end
            end
            default: begin
                state_d = AWAIT_CMD;
            end
        endcase
    end

    always_ff @(posedge sample_clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= AWAIT_CMD;
            bit_cnt <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == AWAIT_CMD) begin
                if (rx_bit.valid) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end else if (expired) begin
                    bit_cnt <= '0;                      // Partial command abandoned
                end
            end
        end
    end

    always_ff @(posedge sample_clk) begin
        if (state_q == AWAIT_CMD && rx_bit.valid) begin
            cmd_q <= {cmd_q[6:0], rx_bit.value};        // MSB first
        end
        if (state_q == AWAIT_STOP && rx_bit.valid) begin
            buttons_q <= buttons;                       // Snapshot at the stop cell
        end
    end

    //////////////////////////////
    // Reply selection
    //////////////////////////////

    always_comb begin
        if (cmd_q == CMD_STATUS) begin
            tx_reply.nbytes = 3'd4;
            tx_reply.data   = buttons_q;
        end else begin
            tx_reply.nbytes = 3'd3;
            tx_reply.data   = {`N64_ID_BYTE0, `N64_ID_BYTE1, `N64_ID_BYTE2, 8'h00};
        end
    end

endmodule

// File: verilog/n64_reply_tx.sv
`include "n64_params.svh"

module n64_reply_tx import n64_pkg::*; (
    input  logic       sample_clk,
    input  logic       arst_n,
    input  logic       us_tick,
    input  logic       tx_start,
    input  n64_reply_t tx_reply,
    output logic       tx_busy,
    output logic       line_drive_low
);

    logic [31:0] shift_q;
    logic [5:0]  cells_left;                // Data bits plus the stop cell
    logic [2:0]  phase;
    logic [2:0]  low_len;
    logic [2:0]  cell_end;
    logic        is_stop;
    logic        busy_q;
    logic        drive_q;

    assign is_stop = (cells_left == 6'd1);

    always_comb begin
        if (is_stop) begin
            low_len  = 3'(`N64_SHORT_LOW_US);
            cell_end = 3'(`N64_SHORT_LOW_US + `N64_CELL_US);  // Stop plus trailing quiet cell
        end else begin
            low_len  = shift_q[31] ? 3'(`N64_SHORT_LOW_US) : 3'(`N64_LONG_LOW_US);
            cell_end = 3'(`N64_CELL_US - 1);
        end
    end

    //////////////////////////////
    // Cell sequencer
    //////////////////////////////

    // Cells start on us_tick, so the first low phase waits for the next tick
    always_ff @(posedge sample_clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q     <= 1'b0;
            drive_q    <= 1'b0;
            cells_left <= '0;
            phase      <= '0;
        end else if (!busy_q) begin
            if (tx_start) begin
                busy_q     <= 1'b1;
                cells_left <= {tx_reply.nbytes, 3'b000} + 6'd1;
                phase      <= '0;
            end
        end else if (us_tick) begin
            drive_q <= (phase < low_len);   // Low phase first, then released
            if (phase == cell_end) begin
                phase <= '0;
                if (is_stop) begin
                    busy_q <= 1'b0;
                end else begin
                    cells_left <= cells_left - 1'b1;
                end
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    always_ff @(posedge sample_clk) begin
        if (!busy_q && tx_start) begin
            shift_q <= tx_reply.data;
        end else if (busy_q && us_tick && (phase == cell_end) && !is_stop) begin
            shift_q <= {shift_q[30:0], 1'b0};   // Next bit, MSB first
        end
    end

    assign tx_busy        = busy_q;
    assign line_drive_low = drive_q;

endmodule

// File: verilog/n64_line_decoder.sv
`include "n64_params.svh"

module n64_line_decoder import n64_pkg::*; (
    input  logic        sample_clk,
    input  logic        arst_n,
    input  logic        line_in,
    input  logic        us_tick,
    output n64_rx_bit_t rx_bit
);

    logic    sync_1;
    logic    sync_2;
    logic    line_q;
    logic    fall;
    logic    rise;
    n64_us_t low_us;

    //////////////////////////////
    // Synchroniser and edges
    //////////////////////////////

    // Idle line is high, so no edge is seen out of reset
    always_ff @(posedge sample_clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_1 <= 1'b1;
            sync_2 <= 1'b1;
            line_q <= 1'b1;
        end else begin
            sync_1 <= line_in;
            sync_2 <= sync_1;
            line_q <= sync_2;
        end
    end

    assign fall = line_q & ~sync_2;
    assign rise = ~line_q & sync_2;

    //////////////////////////////
    // Low phase measurement
    //////////////////////////////

    always_ff @(posedge sample_clk or negedge arst_n) begin
        if (!arst_n) begin
            low_us <= '0;
        end else if (fall) begin
            low_us <= n64_us_t'(us_tick);           // First low cycle may carry a tick
        end else if (!sync_2 && us_tick && (low_us != '1)) begin
            low_us <= low_us + 1'b1;                // Saturates on a stuck line
        end
    end

    always_ff @(posedge sample_clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_bit <= '0;
        end else begin
            rx_bit.valid <= rise && (low_us <= n64_us_t'(`N64_GLITCH_US));
            rx_bit.value <= (low_us <= n64_us_t'(`N64_ONE_MAX_US));  // Short low is a one
        end
    end

endmodule

// File: verilog/n64_bit_timer.sv
`include "n64_params.svh"

module n64_bit_timer import n64_pkg::*; (
    input  logic    sample_clk,
    input  logic    arst_n,
    input  logic    load,
    input  n64_us_t load_us,
    output logic    us_tick,
    output logic    expired
);

    localparam int PRE_W = $clog2(`N64_TICKS_PER_US);

    logic [PRE_W-1:0] pre_cnt;
    n64_us_t          remain;
    logic             armed;

    //////////////////////////////
    // Microsecond prescaler
    //////////////////////////////

    always_ff @(posedge sample_clk or negedge arst_n) begin
        if (!arst_n) begin
            pre_cnt <= '0;
            us_tick <= 1'b0;
        end else if (pre_cnt == PRE_W'(`N64_TICKS_PER_US - 1)) begin
            pre_cnt <= '0;
            us_tick <= 1'b1;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
            us_tick <= 1'b0;
        end
    end

    //////////////////////////////
    // Gap and idle down-counter
    //////////////////////////////

    always_ff @(posedge sample_clk or negedge arst_n) begin
        if (!arst_n) begin
            remain  <= '0;
            armed   <= 1'b0;
            expired <= 1'b0;
        end else begin
            expired <= 1'b0;
            if (load) begin                         // Restart, even while counting
                remain <= load_us;
                armed  <= 1'b1;
            end else if (armed && us_tick) begin
                remain <= remain - 1'b1;
                if (remain <= n64_us_t'(1)) begin   // Last tick of the interval
                    armed   <= 1'b0;
                    expired <= 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/n64_pkg.sv
package n64_pkg;

    typedef logic [7:0] n64_cmd_t;
    typedef logic [4:0] n64_us_t;       // Microsecond count

    localparam n64_cmd_t CMD_INFO   = 8'h00;
    localparam n64_cmd_t CMD_STATUS = 8'h01;
    localparam n64_cmd_t CMD_RESET  = 8'hff;

    typedef enum logic [2:0] {
        AWAIT_CMD,
        AWAIT_STOP,
        REPLY_GAP,
        RESPONDING,
        IGNORING
    } n64_state_t;

    // Sent from bit 31 down to bit 0
    typedef struct packed {
        logic       a;
        logic       b;
        logic       z;
        logic       start;
        logic       d_up;
        logic       d_down;
        logic       d_left;
        logic       d_right;
        logic       rst;                // Set by the L+R+Start combination
        logic       reserved;
        logic       l;
        logic       r;
        logic       c_up;
        logic       c_down;
        logic       c_left;
        logic       c_right;
        logic [7:0] x_axis;
        logic [7:0] y_axis;
    } n64_buttons_t;

    typedef struct packed {
        logic valid;
        logic value;
    } n64_rx_bit_t;

    typedef struct packed {
        logic [2:0]  nbytes;
        logic [31:0] data;              // Left-aligned
    } n64_reply_t;

endpackage

// File: include/n64_params.svh
`ifndef N64_PARAMS_SVH
`define N64_PARAMS_SVH

//////////////////////////////
// Sampling rate
//////////////////////////////

`define N64_TICKS_PER_US 8          // sample_clk cycles per microsecond

//////////////////////////////
// Cell timing, in microseconds
//////////////////////////////

`define N64_CELL_US      4          // Full bit cell
`define N64_SHORT_LOW_US 1          // One cell and stop cell
`define N64_LONG_LOW_US  3          // Zero cell
`define N64_ONE_MAX_US   2          // Decode threshold
`define N64_GLITCH_US    6          // Longer lows are not bits

`define N64_REPLY_GAP_US 2          // Stop cell to first reply cell
`define N64_IDLE_US      12         // Abandon partial or ignored command

//////////////////////////////
// Identity reply
//////////////////////////////

`define N64_ID_BYTE0     8'h05
`define N64_ID_BYTE1     8'h00
`define N64_ID_BYTE2     8'h02

`endif
